//--- logic/drbg_pkg.sv
package drbg_pkg;

    localparam int DIGEST_W = 256;
    localparam int BLOCK_W = 512;
    localparam int SEQ_W = 16;

    typedef logic [DIGEST_W-1:0] digest_t; // entropy, state, digest, output
    typedef logic [BLOCK_W-1:0] block_t;
    typedef logic [SEQ_W-1:0] seq_t;

    // one 1 bit after the message, zeros, then 64-bit length of 256
    localparam digest_t MSG_PAD = {1'b1, 191'b0, 64'd256};

    // sha-256 initial hash, H0 in the top word
    localparam digest_t SHA_H0 = {
        32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
        32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
    };

    typedef enum logic [1:0] {
        ST_EMPTY, // no seed yet
        ST_IDLE,
        ST_HASH,  // core busy
        ST_FOLD
    } drbg_state_t;

endpackage

//--- logic/sha_if.sv
`timescale 1ns/1ns

interface sha_if;

    logic init;                  // request strobe
    drbg_pkg::block_t block;
    logic ready;                 // core idle
    drbg_pkg::digest_t digest;
    logic digest_valid;

    modport client (
        output init,
        output block,
        input ready,
        input digest,
        input digest_valid
    );

    modport core (
        input init,
        input block,
        output ready,
        output digest,
        output digest_valid
    );

endinterface

//--- logic/sha256_core.sv
`timescale 1ns/1ns

module sha256_core (
    input logic clk,
    input logic reset,
    sha_if.core sha
);

    logic [31:0] w [16]; // rolling schedule window, w[0] is W_t
    logic [31:0] a, b, c, d, e, f, g, h;
    logic [5:0] round_cnt;
    logic busy;
    logic finish;
    logic start;
    logic [31:0] t1;
    logic [31:0] t2;
    logic [31:0] w_new;

    function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
        return (x >> n) | (x << (32 - n));
    endfunction

    function automatic logic [31:0] big_sigma0(input logic [31:0] x);
        return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
    endfunction

    function automatic logic [31:0] big_sigma1(input logic [31:0] x);
        return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
    endfunction

    function automatic logic [31:0] small_sigma0(input logic [31:0] x);
        return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
    endfunction

    function automatic logic [31:0] small_sigma1(input logic [31:0] x);
        return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
    endfunction

    // round constant table
    function automatic logic [31:0] k_const(input logic [5:0] idx);
        case (idx)
            6'd0: return 32'h428a2f98;
            6'd1: return 32'h71374491;
            6'd2: return 32'hb5c0fbcf;
            6'd3: return 32'he9b5dba5;
            6'd4: return 32'h3956c25b;
            6'd5: return 32'h59f111f1;
            6'd6: return 32'h923f82a4;
            6'd7: return 32'hab1c5ed5;
            6'd8: return 32'hd807aa98;
            6'd9: return 32'h12835b01;
            6'd10: return 32'h243185be;
            6'd11: return 32'h550c7dc3;
            6'd12: return 32'h72be5d74;
            6'd13: return 32'h80deb1fe;
            6'd14: return 32'h9bdc06a7;
            6'd15: return 32'hc19bf174;
            6'd16: return 32'he49b69c1;
            6'd17: return 32'hefbe4786;
            6'd18: return 32'h0fc19dc6;
            6'd19: return 32'h240ca1cc;
            6'd20: return 32'h2de92c6f;
            6'd21: return 32'h4a7484aa;
            6'd22: return 32'h5cb0a9dc;
            6'd23: return 32'h76f988da;
            6'd24: return 32'h983e5152;
            6'd25: return 32'ha831c66d;
            6'd26: return 32'hb00327c8;
            6'd27: return 32'hbf597fc7;
            6'd28: return 32'hc6e00bf3;
            6'd29: return 32'hd5a79147;
            6'd30: return 32'h06ca6351;
            6'd31: return 32'h14292967;
            6'd32: return 32'h27b70a85;
            6'd33: return 32'h2e1b2138;
            6'd34: return 32'h4d2c6dfc;
            6'd35: return 32'h53380d13;
            6'd36: return 32'h650a7354;
            6'd37: return 32'h766a0abb;
            6'd38: return 32'h81c2c92e;
            6'd39: return 32'h92722c85;
            6'd40: return 32'ha2bfe8a1;
            6'd41: return 32'ha81a664b;
            6'd42: return 32'hc24b8b70;
            6'd43: return 32'hc76c51a3;
            6'd44: return 32'hd192e819;
            6'd45: return 32'hd6990624;
            6'd46: return 32'hf40e3585;
            6'd47: return 32'h106aa070;
            6'd48: return 32'h19a4c116;
            6'd49: return 32'h1e376c08;
            6'd50: return 32'h2748774c;
            6'd51: return 32'h34b0bcb5;
            6'd52: return 32'h391c0cb3;
            6'd53: return 32'h4ed8aa4a;
            6'd54: return 32'h5b9cca4f;
            6'd55: return 32'h682e6ff3;
            6'd56: return 32'h748f82ee;
            6'd57: return 32'h78a5636f;
            6'd58: return 32'h84c87814;
            6'd59: return 32'h8cc70208;
            6'd60: return 32'h90befffa;
            6'd61: return 32'ha4506ceb;
            6'd62: return 32'hbef9a3f7;
            default: return 32'hc67178f2;
        endcase
    endfunction

    assign sha.ready = !busy && !finish;
    assign start = sha.init && sha.ready;

    assign t1 = h + big_sigma1(e) + ((e & f) ^ (~e & g)) + k_const(round_cnt) + w[0];
    assign t2 = big_sigma0(a) + ((a & b) ^ (a & c) ^ (b & c));
    assign w_new = small_sigma1(w[14]) + w[9] + small_sigma0(w[1]) + w[0]; // W_t+16

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            finish <= 1'b0;
            round_cnt <= '0;
            sha.digest_valid <= 1'b0;
        end else begin
            sha.digest_valid <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                round_cnt <= '0;
            end else if (busy) begin
                round_cnt <= round_cnt + 1'b1;
                if (round_cnt == 6'd63) begin
                    busy <= 1'b0;
                    finish <= 1'b1; // final add next
                end
            end else if (finish) begin
                finish <= 1'b0;
                sha.digest_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            for (int i = 0; i < 16; i++) begin
                w[i] <= sha.block[511-32*i -: 32];
            end
            {a, b, c, d, e, f, g, h} <= drbg_pkg::SHA_H0;
        end else if (busy) begin
            for (int i = 0; i < 15; i++) begin
                w[i] <= w[i+1];
            end
            w[15] <= w_new;
            h <= g;
            g <= f;
            f <= e;
            e <= d + t1;
            d <= c;
            c <= b;
            b <= a;
            a <= t1 + t2;
        end else if (finish) begin
            sha.digest <= {
                a + drbg_pkg::SHA_H0[255:224], b + drbg_pkg::SHA_H0[223:192],
                c + drbg_pkg::SHA_H0[191:160], d + drbg_pkg::SHA_H0[159:128],
                e + drbg_pkg::SHA_H0[127:96], f + drbg_pkg::SHA_H0[95:64],
                g + drbg_pkg::SHA_H0[63:32], h + drbg_pkg::SHA_H0[31:0]
            };
        end
    end

endmodule

//--- logic/hash_drbg.sv
`timescale 1ns/1ns

module hash_drbg (
    input logic clk,
    input logic reset,
    input drbg_pkg::digest_t entropy,
    input logic update,
    input logic next,
    input logic do_reseed,
    output logic init_ready,
    output logic next_ready,
    output drbg_pkg::digest_t random_bits,
    output logic random_valid,
    output logic count_strobe,
    output logic clear_strobe,
    sha_if.client sha
);

    drbg_pkg::drbg_state_t state;
    drbg_pkg::digest_t work_state;
    logic take_update;
    logic take_next;

    assign init_ready = (state == drbg_pkg::ST_EMPTY) || (state == drbg_pkg::ST_IDLE);
    assign next_ready = (state == drbg_pkg::ST_IDLE) && !do_reseed && sha.ready;

    // update wins over next in the same cycle
    assign take_update = update && init_ready;
    assign take_next = next && next_ready && !update;

    assign clear_strobe = take_update;
    assign count_strobe = take_next;

    // state stays put while hashing, so block is steady at init
    assign sha.block = {work_state, drbg_pkg::MSG_PAD};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= drbg_pkg::ST_EMPTY;
            sha.init <= 1'b0;
            random_valid <= 1'b0;
            random_bits <= '0;
        end else begin
            sha.init <= 1'b0;
            random_valid <= 1'b0;
            case (state)
                drbg_pkg::ST_EMPTY,
                drbg_pkg::ST_IDLE: begin
                    if (take_update) begin
                        state <= drbg_pkg::ST_IDLE;
                    end else if (take_next) begin
                        state <= drbg_pkg::ST_HASH;
                        sha.init <= 1'b1; // issue cycle
                    end
                end
                drbg_pkg::ST_HASH: begin
                    if (sha.digest_valid) begin
                        random_bits <= sha.digest;
                        random_valid <= 1'b1;
                        state <= drbg_pkg::ST_FOLD;
                    end
                end
                drbg_pkg::ST_FOLD: begin
                    state <= drbg_pkg::ST_IDLE;
                end
                default: begin
                    state <= drbg_pkg::ST_EMPTY;
                end
            endcase
        end
    end

    // working state, new = old + digest + 1 mod 2^256
    always_ff @(posedge clk) begin
        if (take_update) begin
            work_state <= entropy;
        end else if (state == drbg_pkg::ST_FOLD) begin
            work_state <= work_state + random_bits + 1'b1;
        end
    end

endmodule

//--- logic/reseeder.sv
`timescale 1ns/1ns

module reseeder (
    input logic clk,
    input logic reset,
    input logic count_strobe,
    input logic clear_strobe,
    input drbg_pkg::seq_t reseed_limit,
    output logic do_reseed
);

    drbg_pkg::seq_t seq_num;
    drbg_pkg::seq_t seq_next;

    always_comb begin
        seq_next = seq_num;
        if (clear_strobe) begin
            seq_next = '0;
        end else if (seq_num > reseed_limit) begin
            seq_next = reseed_limit; // limit was lowered
        end else if (count_strobe && (seq_num < reseed_limit)) begin
            seq_next = seq_num + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            seq_num <= '0;
            do_reseed <= 1'b0;
        end else begin
            seq_num <= seq_next;
            do_reseed <= (seq_next == reseed_limit); // zero limit reseeds at once
        end
    end

endmodule

//--- logic/drbg_top.sv
`timescale 1ns/1ns

module drbg_top (
    input logic clk,
    input logic reset,
    input drbg_pkg::digest_t entropy,
    input logic update,
    input logic next,
    input drbg_pkg::seq_t reseed_limit,
    output logic init_ready,
    output logic next_ready,
    output logic do_reseed,
    output drbg_pkg::digest_t random_bits,
    output logic random_valid
);

    logic count_strobe;
    logic clear_strobe;

    sha_if sha_bus ();

    hash_drbg hash_drbg_inst (
        .clk          (clk),
        .reset        (reset),
        .entropy      (entropy),
        .update       (update),
        .next         (next),
        .do_reseed    (do_reseed),
        .init_ready   (init_ready),
        .next_ready   (next_ready),
        .random_bits  (random_bits),
        .random_valid (random_valid),
        .count_strobe (count_strobe),
        .clear_strobe (clear_strobe),
        .sha          (sha_bus.client)
    );

    // request count against the limit
    reseeder reseeder_inst (
        .clk          (clk),
        .reset        (reset),
        .count_strobe (count_strobe),
        .clear_strobe (clear_strobe),
        .reseed_limit (reseed_limit),
        .do_reseed    (do_reseed)
    );

    sha256_core sha256_core_inst (
        .clk   (clk),
        .reset (reset),
        .sha   (sha_bus.core)
    );

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk
);

    localparam int HALF_PERIOD = 2; // 4 ns period

    initial clk = 1'b0;

    always #HALF_PERIOD clk = ~clk;

endmodule

//--- sim/drbg_tb.sv
`timescale 1ns/1ns

module drbg_tb;

    localparam int WAIT_LIMIT = 200;
    localparam int GEN_LATENCY = 68;
    // sha-256 of 32 zero bytes
    localparam drbg_pkg::digest_t ZERO_KAT =
        256'h66687aadf862bd776c8fc18b8e9f8e20089714856ee233b3902a591d0d5f2925;

    logic clk;
    logic reset;
    drbg_pkg::digest_t entropy;
    logic update;
    logic next;
    drbg_pkg::seq_t reseed_limit;
    logic init_ready;
    logic next_ready;
    logic do_reseed;
    drbg_pkg::digest_t random_bits;
    logic random_valid;

    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    drbg_pkg::digest_t first_result;
    drbg_pkg::digest_t second_result;

    tb_clock clock_gen (.clk(clk));

    drbg_top drbg_top_inst (
        .clk          (clk),
        .reset        (reset),
        .entropy      (entropy),
        .update       (update),
        .next         (next),
        .reseed_limit (reseed_limit),
        .init_ready   (init_ready),
        .next_ready   (next_ready),
        .do_reseed    (do_reseed),
        .random_bits  (random_bits),
        .random_valid (random_valid)
    );

    task automatic tick();
        @(posedge clk);
        #1; // drive and sample point
    endtask

    task automatic check_digest(input string name, input drbg_pkg::digest_t got,
                                input drbg_pkg::digest_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            $display("error at %0t ns: random_valid latency is %0d, expected %0d",
                     $time, got, exp);
            errors++;
        end
    endtask

    function automatic drbg_pkg::digest_t random_seed();
        drbg_pkg::digest_t v;
        v = '0;
        for (int i = 0; i < 8; i++) begin
            v = {v[223:0], $urandom()};
        end
        return v;
    endfunction

    task automatic load_seed(input drbg_pkg::digest_t seed);
        int n;
        n = 0;
        while (init_ready !== 1'b1 && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (init_ready !== 1'b1) begin
            $display("timeout at %0t ns: init_ready never came high", $time);
            errors++;
        end
        entropy = seed;
        update = 1'b1;
        tick();
        update = 1'b0;
    endtask

    // cycles counts edges from the one that samples next
    task automatic wait_result(inout int cycles, output drbg_pkg::digest_t value);
        value = '0;
        while (random_valid !== 1'b1 && cycles < WAIT_LIMIT) begin
            tick();
            cycles++;
        end
        if (random_valid === 1'b1) begin
            value = random_bits;
        end else begin
            $display("timeout at %0t ns: no random_valid after a generate", $time);
            errors++;
        end
    endtask

    task automatic request_random(output drbg_pkg::digest_t value, output int cycles);
        int n;
        n = 0;
        while (next_ready !== 1'b1 && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (next_ready !== 1'b1) begin
            $display("timeout at %0t ns: next_ready never came high", $time);
            errors++;
        end
        next = 1'b1;
        tick();
        next = 1'b0;
        cycles = 1;
        wait_result(cycles, value);
    endtask

    task automatic expect_no_result(input int span);
        for (int i = 0; i < span; i++) begin
            tick();
            if (random_valid === 1'b1) begin
                $display("random_valid rose at %0t ns with no accepted generate", $time);
                errors++;
            end
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_reset_state();
        int e0;
        e0 = errors;
        check_bit("init_ready", init_ready, 1'b1);
        check_bit("next_ready", next_ready, 1'b0);
        check_bit("do_reseed", do_reseed, 1'b0);
        check_bit("random_valid", random_valid, 1'b0);
        check_digest("random_bits", random_bits, '0);
        next = 1'b1; // unseeded, must be ignored
        tick();
        next = 1'b0;
        expect_no_result(100);
        finish_test("test 1 reset state", e0);
    endtask

    task automatic test_known_answer();
        int e0;
        int cycles;
        drbg_pkg::digest_t value;
        e0 = errors;
        reseed_limit = 16'd4;
        load_seed('0);
        check_bit("next_ready", next_ready, 1'b1);
        request_random(value, cycles);
        check_digest("random_bits", value, ZERO_KAT);
        check_latency(cycles, GEN_LATENCY);
        first_result = value;
        finish_test("test 2 known answer", e0);
    endtask

    task automatic test_state_progression();
        int e0;
        int cycles;
        drbg_pkg::digest_t value;
        e0 = errors;
        request_random(value, cycles);
        check_bit("second result differs", value != first_result, 1'b1);
        check_bit("second result nonzero", value != '0, 1'b1);
        second_result = value;
        finish_test("test 3 state progression", e0);
    endtask

    task automatic test_reseed_demand();
        int e0;
        int cycles;
        drbg_pkg::digest_t value;
        e0 = errors;
        reseed_limit = 16'd3;
        load_seed(random_seed());
        for (int i = 0; i < 3; i++) begin
            request_random(value, cycles);
        end
        tick(); // fold done, back in idle
        check_bit("init_ready", init_ready, 1'b1);
        check_bit("do_reseed", do_reseed, 1'b1);
        check_bit("next_ready", next_ready, 1'b0);
        next = 1'b1; // blocked by the reseed demand
        tick();
        next = 1'b0;
        expect_no_result(100);
        load_seed(random_seed());
        check_bit("do_reseed", do_reseed, 1'b0);
        check_bit("next_ready", next_ready, 1'b1);
        request_random(value, cycles);
        check_latency(cycles, GEN_LATENCY);
        finish_test("test 4 reseed demand", e0);
    endtask

    task automatic test_limit_lowered();
        int e0;
        int n;
        int cycles;
        drbg_pkg::digest_t value;
        e0 = errors;
        reseed_limit = 16'd5;
        load_seed(random_seed());
        request_random(value, cycles);
        request_random(value, cycles);
        check_bit("do_reseed", do_reseed, 1'b0);
        reseed_limit = 16'd1;
        n = 0;
        while (do_reseed !== 1'b1 && n < 2) begin
            tick();
            n++;
        end
        check_bit("do_reseed", do_reseed, 1'b1);
        check_bit("next_ready", next_ready, 1'b0);
        finish_test("test 5 limit lowered", e0);
    endtask

    task automatic test_busy_strobes();
        int e0;
        int cycles;
        drbg_pkg::digest_t value;
        e0 = errors;
        reseed_limit = 16'd4;
        load_seed('0);
        check_bit("next_ready", next_ready, 1'b1);
        next = 1'b1;
        tick();
        next = 1'b0;
        cycles = 1;
        repeat (4) begin
            tick();
            cycles++;
        end
        check_bit("init_ready", init_ready, 1'b0); // core is hashing
        entropy = random_seed();
        update = 1'b1;
        next = 1'b1;
        tick();
        update = 1'b0;
        next = 1'b0;
        cycles++;
        wait_result(cycles, value);
        check_digest("random_bits", value, ZERO_KAT);
        check_latency(cycles, GEN_LATENCY);
        expect_no_result(100);
        // state still follows the zero seed, so next result repeats test 3
        request_random(value, cycles);
        check_digest("random_bits", value, second_result);
        finish_test("test 6 strobes while busy", e0);
    endtask

    initial begin
        reset = 1'b1;
        entropy = '0;
        update = 1'b0;
        next = 1'b0;
        reseed_limit = 16'd4; // nonzero so do_reseed stays low after reset
        void'($urandom(32'hf0dc));
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset_state();
        test_known_answer();
        test_state_progression();
        test_reseed_demand();
        test_limit_lowered();
        test_busy_strobes();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- src.f
logic/drbg_pkg.sv
logic/sha_if.sv
logic/sha256_core.sv
logic/hash_drbg.sv
logic/reseeder.sv
logic/drbg_top.sv
sim/tb_clock.sv
sim/drbg_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= drbg_tb
FILE_LIST ?= src.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --timescale 1ns/1ns
PASS_TEXT ?= Regression passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
